// ==== common/bridge_pkg.sv ====
package bridge_pkg;

	////////////////////
	// serial timing
	////////////////////

	// 50 MHz / 115200 baud
	localparam int clks_per_bit = 434;
	localparam int baud_cnt_w = $clog2(clks_per_bit);
	// last count of a full bit period
	localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(clks_per_bit - 1);
	// last count up to the middle of the start bit
	localparam logic [baud_cnt_w-1:0] baud_half = baud_cnt_w'(clks_per_bit / 2 - 1);

	////////////////////
	// flash array
	////////////////////

	localparam int flash_depth = 256;
	// program and erase hold off ack this long
	localparam int flash_busy_cycles = 4;
	localparam int busy_cnt_w = $clog2(flash_busy_cycles + 1);
	localparam logic [busy_cnt_w-1:0] busy_last = busy_cnt_w'(flash_busy_cycles);

	////////////////////
	// host commands
	////////////////////

	// ascii W, E, R
	localparam logic [7:0] cmd_write = 8'h57;
	localparam logic [7:0] cmd_erase = 8'h45;
	localparam logic [7:0] cmd_read = 8'h52;
	// ascii ? sent back for anything else
	localparam logic [7:0] reply_bad = 8'h3F;

	// wishbone classic, master to slave
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		// erase tag, only meaningful with we
		logic       erase;
		logic [7:0] adr;
		logic [7:0] dat;
	} wb_m2s_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_s2m_t;

	// one host frame as received
	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] addr;
		logic [7:0] data;
	} frame_t;

endpackage

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import bridge_pkg::*; (
	input  logic       CLK_50MHZ,
	input  logic       RST,
	input  logic       rxd,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [baud_cnt_w-1:0] cnt;
	logic [2:0] bit_idx;

	// two flop synchronizer, line idles high
	always_ff @(posedge CLK_50MHZ) begin
		if (RST) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
		end
	end

	////////////////////
	// bit sampler
	////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (RST) begin
			state <= st_idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					cnt <= '0;
					bit_idx <= '0;
					// falling edge starts a frame
					if (!rx_sync)
						state <= st_start;
				end
				st_start: begin
					if (cnt == baud_half) begin
						cnt <= '0;
						// glitch, not a real start bit
						state <= rx_sync ? st_idle : st_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_data: begin
					if (cnt == baud_last) begin
						cnt <= '0;
						// lsb first
						rx_byte <= {rx_sync, rx_byte[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_stop: begin
					if (cnt == baud_last) begin
						cnt <= '0;
						state <= st_idle;
						// low stop bit drops the byte
						rx_valid <= rx_sync;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import bridge_pkg::*; (
	input  logic       CLK_50MHZ,
	input  logic       RST,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       txd,
	output logic       tx_busy
);

	// stop, data, start from msb down
	logic [9:0] shift_q;
	logic [baud_cnt_w-1:0] cnt;
	logic [3:0] bit_idx;

	////////////////////
	// shifter
	////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (RST) begin
			shift_q <= '1;
			tx_busy <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				shift_q <= {1'b1, tx_byte, 1'b0};
				tx_busy <= 1'b1;
				cnt <= '0;
				bit_idx <= '0;
			end
		end else if (cnt == baud_last) begin
			cnt <= '0;
			// refill with ones so the line ends idle
			shift_q <= {1'b1, shift_q[9:1]};
			if (bit_idx == 4'd9)
				tx_busy <= 1'b0;
			else
				bit_idx <= bit_idx + 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// lsb of the shifter is the line
	assign txd = shift_q[0];

endmodule

// ==== flash/flash_array.sv ====
`timescale 1ns/1ps

module flash_array import bridge_pkg::*; (
	input  logic    CLK_50MHZ,
	input  logic    RST,
	input  wb_m2s_t wb_in,
	output wb_s2m_t wb_out
);

	logic [7:0] mem [flash_depth];
	logic ack_q;
	logic [7:0] dat_q;
	logic [busy_cnt_w-1:0] wait_cnt;
	logic [busy_cnt_w-1:0] wait_last;
	logic [7:0] cur_val;
	logic [7:0] new_val;
	logic req;
	logic done;

	// live request, one ack per cycle
	assign req = wb_in.cyc && wb_in.stb && !ack_q;
	// reads take one wait, program and erase the busy time
	assign wait_last = wb_in.we ? busy_last : '0;
	assign done = req && (wait_cnt == wait_last);

	assign cur_val = mem[wb_in.adr];
	// nor style program only clears bits
	assign new_val = wb_in.erase ? 8'hFF : (cur_val & wb_in.dat);

	////////////////////
	// array and handshake
	////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (RST) begin
			// whole array erased
			for (int i = 0; i < flash_depth; i++)
				mem[i] <= 8'hFF;
			ack_q <= 1'b0;
			wait_cnt <= '0;
		end else begin
			ack_q <= done;
			if (done) begin
				wait_cnt <= '0;
				if (wb_in.we)
					mem[wb_in.adr] <= new_val;
			end else if (req) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0;
			end
		end
	end

	// stored value after the commit, valid with ack
	always_ff @(posedge CLK_50MHZ) begin
		if (done)
			dat_q <= wb_in.we ? new_val : cur_val;
	end

	assign wb_out.ack = ack_q;
	assign wb_out.dat = dat_q;

endmodule

// ==== source/command_manager.sv ====
`timescale 1ns/1ps

module command_manager import bridge_pkg::*; (
	input  logic       CLK_50MHZ,
	input  logic       RST,
	input  logic [7:0] rx_byte,
	input  logic       rx_valid,
	output logic [7:0] tx_byte,
	output logic       tx_start,
	input  logic       tx_busy,
	output wb_m2s_t    wb_out,
	input  wb_s2m_t    wb_in
);

	typedef enum logic [2:0] {
		st_wait_cmd,
		st_wait_addr,
		st_wait_data,
		st_bus_cycle,
		st_send_addr,
		st_send_data
	} mgr_state_t;

	mgr_state_t state;
	frame_t frame;
	logic [7:0] reply_data;
	logic cmd_known;

	// only W, E and R reach the array
	assign cmd_known = (frame.cmd == cmd_write) || (frame.cmd == cmd_erase) ||
		(frame.cmd == cmd_read);

	////////////////////
	// control FSM
	////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (RST) begin
			state <= st_wait_cmd;
		end else begin
			case (state)
				st_wait_cmd: begin
					if (rx_valid)
						state <= st_wait_addr;
				end
				st_wait_addr: begin
					if (rx_valid)
						state <= st_wait_data;
				end
				st_wait_data: begin
					// unknown command goes straight to the reply
					if (rx_valid)
						state <= cmd_known ? st_bus_cycle : st_send_addr;
				end
				st_bus_cycle: begin
					// cyc and stb drop with the state change
					if (wb_in.ack)
						state <= st_send_addr;
				end
				st_send_addr: begin
					if (!tx_busy)
						state <= st_send_data;
				end
				st_send_data: begin
					// transmitter still busy with the address byte here
					if (!tx_busy)
						state <= st_wait_cmd;
				end
				default: state <= st_wait_cmd;
			endcase
		end
	end

	////////////////////
	// frame and reply
	////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		case (state)
			st_wait_cmd: begin
				if (rx_valid)
					frame.cmd <= rx_byte;
			end
			st_wait_addr: begin
				if (rx_valid)
					frame.addr <= rx_byte;
			end
			st_wait_data: begin
				if (rx_valid) begin
					frame.data <= rx_byte;
					// overwritten on ack for a known command
					reply_data <= reply_bad;
				end
			end
			st_bus_cycle: begin
				if (wb_in.ack)
					reply_data <= wb_in.dat;
			end
			default: ;
		endcase
	end

	// one pulse per reply byte, only with the transmitter idle
	assign tx_start = !tx_busy && ((state == st_send_addr) || (state == st_send_data));
	assign tx_byte = (state == st_send_data) ? reply_data : frame.addr;

	// bus signals held stable for the whole cycle
	always_comb begin
		wb_out.cyc = (state == st_bus_cycle);
		wb_out.stb = (state == st_bus_cycle);
		wb_out.we = (frame.cmd != cmd_read);
		wb_out.erase = (frame.cmd == cmd_erase);
		wb_out.adr = frame.addr;
		wb_out.dat = frame.data;
	end

endmodule

// ==== source/uart_flash_bridge.sv ====
`timescale 1ns/1ps

module uart_flash_bridge import bridge_pkg::*; (
	input  logic CLK_50MHZ,
	input  logic RST,
	input  logic rs_rxd,
	output logic rs_txd
);

	logic [7:0] rx_byte;
	logic rx_valid;
	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;
	wb_m2s_t wb_m2s;
	wb_s2m_t wb_s2m;

	////////////////////
	// serial side
	////////////////////

	uart_rx uart_rx_inst (
		.CLK_50MHZ(CLK_50MHZ),
		.RST(RST),
		.rxd(rs_rxd),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	uart_tx uart_tx_inst (
		.CLK_50MHZ(CLK_50MHZ),
		.RST(RST),
		.tx_byte(tx_byte),
		.tx_start(tx_start),
		.txd(rs_txd),
		.tx_busy(tx_busy)
	);

	// frame decode and wishbone master
	command_manager command_manager_inst (
		.CLK_50MHZ(CLK_50MHZ),
		.RST(RST),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.tx_byte(tx_byte),
		.tx_start(tx_start),
		.tx_busy(tx_busy),
		.wb_out(wb_m2s),
		.wb_in(wb_s2m)
	);

	flash_array flash_array_inst (
		.CLK_50MHZ(CLK_50MHZ),
		.RST(RST),
		.wb_in(wb_m2s),
		.wb_out(wb_s2m)
	);

endmodule

// ==== verification/tb_uart_flash_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_flash_bridge import bridge_pkg::*; ();

	localparam string trace_path = "verification/bridge_trace.txt";
	// one serial byte on the wire
	localparam int frame_cycles = 10 * clks_per_bit;

	logic CLK_50MHZ;
	logic RST;
	logic rs_rxd;
	logic rs_txd;

	// trace contents, one entry per transaction
	frame_t trace_frame [$];
	logic [15:0] trace_exp [$];
	logic [7:0] trace_num [$];
	// reply bytes as they come off rs_txd
	logic [7:0] reply_q [$];
	int err_cnt;
	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;
	int cycle_limit;
	logic [31:0] lcg_state;

	uart_flash_bridge uart_flash_bridge_inst (
		.CLK_50MHZ(CLK_50MHZ),
		.RST(RST),
		.rs_rxd(rs_rxd),
		.rs_txd(rs_txd)
	);

	// 50 MHz
	initial begin
		CLK_50MHZ = 1'b0;
		forever #10 CLK_50MHZ = ~CLK_50MHZ;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, got);
			err_cnt++;
		end
	endtask

	// host side 8N1, lsb first, caller sits on a falling edge
	task automatic send_byte(input logic [7:0] b);
		rs_rxd = 1'b0;
		repeat (clks_per_bit) @(negedge CLK_50MHZ);
		for (int i = 0; i < 8; i++) begin
			rs_rxd = b[i];
			repeat (clks_per_bit) @(negedge CLK_50MHZ);
		end
		rs_rxd = 1'b1;
		repeat (clks_per_bit) @(negedge CLK_50MHZ);
	endtask

	// start edge, then mid-bit samples up to the stop bit
	task automatic receive_byte(output logic [7:0] b, output logic stop_ok);
		while (rs_txd !== 1'b1)
			@(negedge CLK_50MHZ);
		while (rs_txd !== 1'b0)
			@(negedge CLK_50MHZ);
		repeat (clks_per_bit / 2) @(negedge CLK_50MHZ);
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge CLK_50MHZ);
			b[i] = rs_txd;
		end
		repeat (clks_per_bit) @(negedge CLK_50MHZ);
		stop_ok = rs_txd;
	endtask

	task automatic load_trace(output logic ok);
		int fd;
		int code;
		int n;
		string line;
		logic [7:0] num;
		logic [7:0] cmd_b;
		logic [7:0] addr_b;
		logic [7:0] data_b;
		logic [7:0] exp_a;
		logic [7:0] exp_d;
		ok = 1'b0;
		fd = $fopen(trace_path, "r");
		if (fd == 0) begin
			$display("cannot open trace file %s", trace_path);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				// skip blank and # lines
				if (code != 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h", num, cmd_b, addr_b, data_b,
						exp_a, exp_d);
					if (n == 6) begin
						trace_num.push_back(num);
						trace_frame.push_back({cmd_b, addr_b, data_b});
						trace_exp.push_back({exp_a, exp_d});
					end
				end
			end
			$fclose(fd);
			if (trace_frame.size() == 0)
				$display("trace file %s holds no transactions", trace_path);
			else
				ok = 1'b1;
		end
	endtask

	////////////////////
	// watchdog and reply monitor
	////////////////////

	// armed once the trace length is known
	initial begin
		while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
			@(posedge CLK_50MHZ);
			cycle_cnt++;
		end
		$display("run timed out after %0d cycles without finishing the trace", cycle_cnt);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [7:0] b;
		logic stop_ok;
		forever begin
			receive_byte(b, stop_ok);
			if (!stop_ok) begin
				$display("reply byte %h had a low stop bit at %0t ns", b, $time);
				err_cnt++;
			end
			reply_q.push_back(b);
		end
	end

	////////////////////
	// main sequence
	////////////////////

	initial begin
		logic ok;
		int gap;
		int errs_before;
		logic [7:0] got_addr;
		logic [7:0] got_data;
		frame_t f;
		RST = 1'b1;
		rs_rxd = 1'b1;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		lcg_state = 32'd79;
		load_trace(ok);
		if (!ok) begin
			$display("=== FAIL ===");
			$finish;
		end else begin
			// 40 byte times per transaction plus reset margin
			cycle_limit = trace_frame.size() * 40 * frame_cycles + 20 * frame_cycles;
			repeat (4) @(negedge CLK_50MHZ);
			RST = 1'b0;
			for (int t = 0; t < trace_frame.size(); t++) begin
				f = trace_frame[t];
				// every fourth frame goes out right after the last reply
				if (t % 4 == 3)
					gap = 0;
				else
					gap = int'((lcg_next() >> 16) % 2001);
				repeat (gap) @(negedge CLK_50MHZ);
				errs_before = err_cnt;
				send_byte(f.cmd);
				send_byte(f.addr);
				send_byte(f.data);
				// address then data, done at the second stop bit
				while (reply_q.size() < 2)
					@(negedge CLK_50MHZ);
				got_addr = reply_q.pop_front();
				got_data = reply_q.pop_front();
				check_byte(got_addr, trace_exp[t][15:8], "reply address");
				check_byte(got_data, trace_exp[t][7:0], "reply data");
				if (err_cnt == errs_before)
					pass_cnt++;
				else
					fail_cnt++;
				$display("test %02h %s: cmd %h addr %h data %h, reply %h %h", trace_num[t],
					(err_cnt == errs_before) ? "passed" : "FAILED", f.cmd, f.addr, f.data,
					got_addr, got_data);
			end
			$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0 && err_cnt == 0)
				$display("=== PASS ===");
			else
				$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

// ==== verification/bridge_trace.txt ====
# columns: test, cmd, addr, data, expected reply addr, expected reply data (hex)
# cmd 57 = W program, 45 = E erase, 52 = R read, anything else unknown
01 52 10 00 10 ff
02 57 42 a5 42 a5
03 57 42 3c 42 24
04 52 42 00 42 24
05 45 42 99 42 ff
06 52 42 00 42 ff
07 57 00 5a 00 5a
08 57 ff c3 ff c3
09 57 01 0f 01 0f
0a 52 00 00 00 5a
0b 52 ff 00 ff c3
0c 52 01 00 01 0f
0d 58 01 00 01 3f
0e 52 01 00 01 0f
0f 00 7e 12 7e 3f
10 52 7e 00 7e ff
11 57 fe 00 fe 00
12 52 ff 00 ff c3

// ==== compile.f ====
common/bridge_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
flash/flash_array.sv
source/command_manager.sv
source/uart_flash_bridge.sv
verification/tb_uart_flash_bridge.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_uart_flash_bridge -f compile.f -o tb_sim
	obj_dir/tb_sim | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
